// ==== vlog.f ====
verilog/rt_config_pkg.sv
verilog/rt_types_pkg.sv
verilog/job_arbiter.sv
verilog/node_fetch.sv
verilog/ray_fetch.sv
verilog/trav_step.sv
verilog/trav_pipe.sv
testbench/trav_pipe_props.sv
testbench/trav_pipe_tb.sv

// ==== Makefile ====
VERILATOR  ?= verilator
FLAGS      := --binary --timing --assert --timescale 1ns/1ps
LINT_FLAGS := --lint-only --timing --assert --timescale 1ns/1ps
TOP        := trav_pipe_tb
LINT_TOP   := trav_pipe
FILELIST   := vlog.f
OBJ_DIR    := obj_dir
SIM_ARGS   := +verilator+error+limit+1000
LOG        := sim.log

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(LINT_TOP)

$(OBJ_DIR)/V$(TOP): $(shell cat $(FILELIST))
	$(VERILATOR) $(FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	-./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q -e "Test failed" -e "%Error" $(LOG) || ! grep -q "Test passed" $(LOG); then \
		echo "simulation FAILED"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== testbench/trav_pipe_tb.sv ====
`default_nettype none

module trav_pipe_tb
	import rt_config_pkg::*;
();
	timeunit 1ns;
	timeprecision 1ps;

	localparam int NUM_JOBS   = 300;
	localparam int RST_CYCLES = 8;
	localparam int WATCHDOG_CYCLES = RST_CYCLES + NUM_NODES + NUM_RAYS + NUM_JOBS * 20;

	logic                 clk = 1'b0;
	logic                 rst;
	logic                 new_valid;
	logic [RAY_ID_W-1:0]  new_ray_id;
	logic [NODE_ID_W-1:0] new_node_id;
	logic                 new_stall;
	logic                 rst_valid;
	logic [RAY_ID_W-1:0]  rst_ray_id;
	logic [NODE_ID_W-1:0] rst_node_id;
	logic                 rst_stall;
	logic                 node_we;
	logic [NODE_ID_W-1:0] node_waddr;
	logic [NODE_W-1:0]    node_wdata;
	logic                 ray_we;
	logic [RAY_ID_W-1:0]  ray_waddr;
	logic [RAY_W-1:0]     ray_wdata;
	logic                 res_valid;
	logic [RAY_ID_W-1:0]  res_ray_id;
	logic                 res_leaf;
	logic [LIST_W-1:0]    res_value;
	logic [COUNT_W-1:0]   res_count;
	logic                 res_stall;

	// handshakes seen at the last rising edge
	logic                new_took = 1'b0;
	logic                rst_took = 1'b0;
	logic                res_took = 1'b0;
	logic [RAY_ID_W-1:0] res_took_id;

	logic [NUM_RAYS-1:0] busy = '0;
	int presented = 0;
	int issued    = 0;
	int received  = 0;
	int errors    = 0;

	trav_pipe uut (.*);

	always #5 clk = ~clk;

	always @(posedge clk) begin
		new_took    <= new_valid && !new_stall;
		rst_took    <= rst_valid && !rst_stall;
		res_took    <= res_valid && !res_stall;
		res_took_id <= res_ray_id;
	end

	// reserve a ray id with no job in flight
	task automatic claim_ray(output logic found, output logic [RAY_ID_W-1:0] id);
		logic [RAY_ID_W-1:0] start;
		start = RAY_ID_W'($urandom);
		found = 1'b0;
		id    = start;
		for (int i = 0; i < NUM_RAYS; i++) begin
			if (!found && !busy[RAY_ID_W'(int'(start) + i)]) begin
				found = 1'b1;
				id    = RAY_ID_W'(int'(start) + i);
			end
		end
		if (found) begin
			busy[id] = 1'b1;
		end
	endtask

	task automatic load_stores();
		for (int a = 0; a < NUM_NODES; a++) begin
			@(negedge clk);
			node_we    = 1'b1;
			node_waddr = NODE_ID_W'(a);
			node_wdata = $urandom;
		end
		@(negedge clk);
		node_we = 1'b0;
		for (int a = 0; a < NUM_RAYS; a++) begin
			ray_we    = 1'b1;
			ray_waddr = RAY_ID_W'(a);
			ray_wdata = RAY_W'({$urandom, $urandom});
			@(negedge clk);
		end
		ray_we = 1'b0;
	endtask

	task automatic run_jobs();
		logic                found;
		logic [RAY_ID_W-1:0] id;
		while (received < NUM_JOBS) begin
			@(negedge clk);
			if (res_took) begin
				busy[res_took_id] = 1'b0;
				received++;
			end
			if (new_took) begin
				new_valid = 1'b0;
				issued++;
			end
			if (rst_took) begin
				rst_valid = 1'b0;
				issued++;
			end
			if (!new_valid && presented < NUM_JOBS && $urandom % 3 != 0) begin
				claim_ray(found, id);
				if (found) begin
					new_valid   = 1'b1;
					new_ray_id  = id;
					new_node_id = NODE_ID_W'($urandom);
					presented++;
				end
			end
			if (!rst_valid && presented < NUM_JOBS && $urandom % 3 != 0) begin
				claim_ray(found, id);
				if (found) begin
					rst_valid   = 1'b1;
					rst_ray_id  = id;
					rst_node_id = NODE_ID_W'($urandom);
					presented++;
				end
			end
			res_stall = ($urandom % 4 == 0);
		end
		res_stall = 1'b0;
	endtask

	initial begin
		void'($urandom(32'h8175));
		rst         = 1'b1;
		new_valid   = 1'b0;
		new_ray_id  = '0;
		new_node_id = '0;
		rst_valid   = 1'b0;
		rst_ray_id  = '0;
		rst_node_id = '0;
		node_we     = 1'b0;
		node_waddr  = '0;
		node_wdata  = '0;
		ray_we      = 1'b0;
		ray_waddr   = '0;
		ray_wdata   = '0;
		res_stall   = 1'b0;
		repeat (RST_CYCLES) @(negedge clk);
		rst = 1'b0;
		load_stores();
		repeat (2) @(negedge clk);
		run_jobs();
		repeat (6) @(negedge clk);
		if (res_valid) begin
			errors++;
			$display("extra result for ray %h after every job was answered", res_ray_id);
		end
		if (issued != received) begin
			errors++;
			$display("accepted %0d jobs but got %0d results", issued, received);
		end
		errors += uut.props.fail_count;
		$display("jobs issued %0d, results received %0d, errors %0d", issued, received, errors);
		if (errors == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("timeout: only %0d of %0d results after %0d cycles",
			received, NUM_JOBS, WATCHDOG_CYCLES);
		$display("Test failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== testbench/trav_pipe_props.sv ====
`default_nettype none

module trav_pipe_props
	import rt_config_pkg::*;
	import rt_types_pkg::*;
(
	input logic                 clk,
	input logic                 rst,
	input logic                 new_valid,
	input logic [RAY_ID_W-1:0]  new_ray_id,
	input logic [NODE_ID_W-1:0] new_node_id,
	input logic                 new_stall,
	input logic                 rst_valid,
	input logic [RAY_ID_W-1:0]  rst_ray_id,
	input logic [NODE_ID_W-1:0] rst_node_id,
	input logic                 rst_stall,
	input logic                 node_we,
	input logic [NODE_ID_W-1:0] node_waddr,
	input logic [NODE_W-1:0]    node_wdata,
	input logic                 ray_we,
	input logic [RAY_ID_W-1:0]  ray_waddr,
	input logic [RAY_W-1:0]     ray_wdata,
	input logic                 res_valid,
	input logic [RAY_ID_W-1:0]  res_ray_id,
	input logic                 res_leaf,
	input logic [LIST_W-1:0]    res_value,
	input logic [COUNT_W-1:0]   res_count,
	input logic                 res_stall
);
	timeunit 1ns;
	timeprecision 1ps;

	tree_node_u           node_shadow [NUM_NODES];
	logic [RAY_W-1:0]     ray_shadow [NUM_RAYS];
	logic [NODE_ID_W-1:0] job_node [NUM_RAYS];
	logic [NUM_RAYS-1:0]  pending;
	logic                 seen_job;
	logic                 last_new;
	logic                 acc_new;
	logic                 acc_rst;
	tree_node_u           job_word;
	logic                 exp_leaf;
	logic [LIST_W-1:0]    exp_value;
	logic [COUNT_W-1:0]   exp_count;
	int                   fail_count = 0;

	// child on the origin side of the split plane
	function automatic logic [NODE_ID_W-1:0] near_child(tree_node_u n, logic [RAY_W-1:0] r);
		logic [COORD_W-1:0] org;
		logic               neg;
		logic               upper;
		case (n.inner.kind)
			NODE_SPLIT_X: begin
				org = r[3+2*COORD_W +: COORD_W];
				neg = r[2];
			end
			NODE_SPLIT_Y: begin
				org = r[3+COORD_W +: COORD_W];
				neg = r[1];
			end
			default: begin
				org = r[3 +: COORD_W];
				neg = r[0];
			end
		endcase
		upper = !($signed(org) < $signed(n.inner.split));
		if (neg) begin
			upper = !upper;
		end
		return n.inner.left + NODE_ID_W'(upper);
	endfunction

	assign acc_new = new_valid && !new_stall;
	assign acc_rst = rst_valid && !rst_stall;

	assign job_word  = node_shadow[job_node[res_ray_id]];
	assign exp_leaf  = (job_word.leaf.kind == NODE_LEAF);
	assign exp_value = exp_leaf ? job_word.leaf.list
		: LIST_W'(near_child(job_word, ray_shadow[res_ray_id]));
	assign exp_count = exp_leaf ? job_word.leaf.count : '0;

	always_ff @(posedge clk) begin
		if (node_we) begin
			node_shadow[node_waddr] <= node_wdata;
		end
		if (ray_we) begin
			ray_shadow[ray_waddr] <= ray_wdata;
		end
		if (acc_new) begin
			job_node[new_ray_id] <= new_node_id;
		end
		if (acc_rst) begin
			job_node[rst_ray_id] <= rst_node_id;
		end
	end

	// one bit per ray id that has a job in flight
	always_ff @(posedge clk) begin
		if (rst) begin
			pending  <= '0;
			seen_job <= 1'b0;
			last_new <= 1'b0;
		end else begin
			if (res_valid && !res_stall) begin
				pending[res_ray_id] <= 1'b0;
			end
			if (acc_new) begin
				pending[new_ray_id] <= 1'b1;
			end
			if (acc_rst) begin
				pending[rst_ray_id] <= 1'b1;
			end
			if (acc_new || acc_rst) begin
				seen_job <= 1'b1;
				last_new <= acc_new;
			end
		end
	end

	// new rays have priority, only a losing restart may stall here
	idle_after_reset: assert property (@(posedge clk) disable iff (rst)
		!seen_job |-> !res_valid && !new_stall && !(rst_stall && !new_valid))
	else begin
		fail_count++;
		$error("result or stall raised before the first job was accepted");
	end

	result_outstanding: assert property (@(posedge clk) disable iff (rst)
		res_valid |-> pending[res_ray_id])
	else begin
		fail_count++;
		$error("result for ray %h which has no job in flight", $sampled(res_ray_id));
	end

	leaf_flag: assert property (@(posedge clk) disable iff (rst)
		res_valid && pending[res_ray_id] |-> res_leaf == exp_leaf)
	else begin
		fail_count++;
		$error("ERROR res_leaf got %h expected %h", $sampled(res_leaf), $sampled(exp_leaf));
	end

	value_match: assert property (@(posedge clk) disable iff (rst)
		res_valid && pending[res_ray_id] |-> res_value == exp_value)
	else begin
		fail_count++;
		$error("ERROR res_value got %h expected %h", $sampled(res_value), $sampled(exp_value));
	end

	count_match: assert property (@(posedge clk) disable iff (rst)
		res_valid && pending[res_ray_id] |-> res_count == exp_count)
	else begin
		fail_count++;
		$error("ERROR res_count got %h expected %h", $sampled(res_count), $sampled(exp_count));
	end

	result_held: assert property (@(posedge clk) disable iff (rst)
		res_valid && res_stall |=>
		res_valid && $stable({res_ray_id, res_leaf, res_value, res_count}))
	else begin
		fail_count++;
		$error("result changed while the output was stalled");
	end

	// with both sources waiting the winner is never last time's winner
	grants_alternate: assert property (@(posedge clk) disable iff (rst)
		new_valid && rst_valid && (acc_new || acc_rst) |-> acc_new != last_new)
	else begin
		fail_count++;
		$error("arbiter granted the same source twice in a row");
	end

endmodule

bind trav_pipe trav_pipe_props props (
	.clk, .rst,
	.new_valid, .new_ray_id, .new_node_id, .new_stall,
	.rst_valid, .rst_ray_id, .rst_node_id, .rst_stall,
	.node_we, .node_waddr, .node_wdata,
	.ray_we, .ray_waddr, .ray_wdata,
	.res_valid, .res_ray_id, .res_leaf, .res_value, .res_count, .res_stall
);

`default_nettype wire

// ==== verilog/trav_pipe.sv ====
`default_nettype none

module trav_pipe
	import rt_config_pkg::*;
	import rt_types_pkg::*;
(
	input  logic                 clk,
	input  logic                 rst,

	// new rays from scene intersection
	input  logic                 new_valid,
	input  logic [RAY_ID_W-1:0]  new_ray_id,
	input  logic [NODE_ID_W-1:0] new_node_id,
	output logic                 new_stall,

	// restarts from the short stack
	input  logic                 rst_valid,
	input  logic [RAY_ID_W-1:0]  rst_ray_id,
	input  logic [NODE_ID_W-1:0] rst_node_id,
	output logic                 rst_stall,

	input  logic                 node_we,
	input  logic [NODE_ID_W-1:0] node_waddr,
	input  logic [NODE_W-1:0]    node_wdata,

	input  logic                 ray_we,
	input  logic [RAY_ID_W-1:0]  ray_waddr,
	input  logic [RAY_W-1:0]     ray_wdata,

	output logic                 res_valid,
	output logic [RAY_ID_W-1:0]  res_ray_id,
	output logic                 res_leaf,
	output logic [LIST_W-1:0]    res_value,
	output logic [COUNT_W-1:0]   res_count,
	input  logic                 res_stall
);

	// arbiter to node fetch
	logic                 arb_valid;
	logic [RAY_ID_W-1:0]  arb_ray_id;
	logic [NODE_ID_W-1:0] arb_node_id;
	logic                 arb_stall;

	// node fetch to ray fetch
	logic                 nf_valid;
	logic [RAY_ID_W-1:0]  nf_ray_id;
	tree_node_u           nf_node;
	logic                 nf_stall;

	// ray fetch to traversal
	logic                 rf_valid;
	logic [RAY_ID_W-1:0]  rf_ray_id;
	tree_node_u           rf_node;
	logic [COORD_W-1:0]   rf_origin;
	logic                 rf_dir_neg;
	logic                 rf_stall;

	job_arbiter tarb (
		.clk, .rst,
		.new_valid, .new_ray_id, .new_node_id, .new_stall,
		.rst_valid, .rst_ray_id, .rst_node_id, .rst_stall,
		.out_valid(arb_valid), .out_ray_id(arb_ray_id),
		.out_node_id(arb_node_id), .out_stall(arb_stall)
	);

	node_fetch nfetch (
		.clk, .rst,
		.node_we, .node_waddr, .node_wdata,
		.in_valid(arb_valid), .in_ray_id(arb_ray_id),
		.in_node_id(arb_node_id), .in_stall(arb_stall),
		.out_valid(nf_valid), .out_ray_id(nf_ray_id),
		.out_node(nf_node), .out_stall(nf_stall)
	);

	ray_fetch rfetch (
		.clk, .rst,
		.ray_we, .ray_waddr, .ray_wdata,
		.in_valid(nf_valid), .in_ray_id(nf_ray_id),
		.in_node(nf_node), .in_stall(nf_stall),
		.out_valid(rf_valid), .out_ray_id(rf_ray_id), .out_node(rf_node),
		.out_origin(rf_origin), .out_dir_neg(rf_dir_neg), .out_stall(rf_stall)
	);

	trav_step trav (
		.clk, .rst,
		.in_valid(rf_valid), .in_ray_id(rf_ray_id), .in_node(rf_node),
		.in_origin(rf_origin), .in_dir_neg(rf_dir_neg), .in_stall(rf_stall),
		.res_valid, .res_ray_id, .res_leaf, .res_value, .res_count, .res_stall
	);

endmodule

`default_nettype wire

// ==== verilog/trav_step.sv ====
`default_nettype none

module trav_step
	import rt_config_pkg::*;
	import rt_types_pkg::*;
(
	input  logic                clk,
	input  logic                rst,

	input  logic                in_valid,
	input  logic [RAY_ID_W-1:0] in_ray_id,
	input  tree_node_u          in_node,
	input  logic [COORD_W-1:0]  in_origin,
	input  logic                in_dir_neg,
	output logic                in_stall,

	output logic                res_valid,
	output logic [RAY_ID_W-1:0] res_ray_id,
	output logic                res_leaf,
	output logic [LIST_W-1:0]   res_value,
	output logic [COUNT_W-1:0]  res_count,
	input  logic                res_stall
);

	logic                 is_leaf;
	logic                 upper;
	logic [NODE_ID_W-1:0] next_id;
	logic                 accept;

	assign in_stall = res_valid && res_stall;
	assign accept   = in_valid && !in_stall;

	assign is_leaf = (in_node.leaf.kind == NODE_LEAF);

	// signed fixed-point compare, flipped for a negative direction
	assign upper = ($signed(in_origin) >= $signed(in_node.inner.split)) ^ in_dir_neg;

	// children are adjacent, upper one follows the left id
	assign next_id = in_node.inner.left + NODE_ID_W'(upper);

	always_ff @(posedge clk) begin
		if (rst) begin
			res_valid <= 1'b0;
		end else if (!in_stall) begin
			res_valid <= in_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			res_ray_id <= in_ray_id;
			res_leaf   <= is_leaf;
			if (is_leaf) begin
				res_value <= in_node.leaf.list;
				res_count <= in_node.leaf.count;
			end else begin
				res_value <= LIST_W'(next_id);
				res_count <= '0;
			end
		end
	end

endmodule

`default_nettype wire

// ==== verilog/ray_fetch.sv ====
`default_nettype none

module ray_fetch
	import rt_config_pkg::*;
	import rt_types_pkg::*;
(
	input  logic                clk,
	input  logic                rst,

	// store write port
	input  logic                ray_we,
	input  logic [RAY_ID_W-1:0] ray_waddr,
	input  logic [RAY_W-1:0]    ray_wdata,

	input  logic                in_valid,
	input  logic [RAY_ID_W-1:0] in_ray_id,
	input  tree_node_u          in_node,
	output logic                in_stall,

	output logic                out_valid,
	output logic [RAY_ID_W-1:0] out_ray_id,
	output tree_node_u          out_node,
	output logic [COORD_W-1:0]  out_origin,
	output logic                out_dir_neg,
	input  logic                out_stall
);

	logic [RAY_W-1:0] ray_mem [NUM_RAYS];
	logic [RAY_W-1:0] ray_q;
	logic             accept;

	logic [COORD_W-1:0] org_x;
	logic [COORD_W-1:0] org_y;
	logic [COORD_W-1:0] org_z;

	assign in_stall = out_valid && out_stall;
	assign accept   = in_valid && !in_stall;

	always_ff @(posedge clk) begin
		if (ray_we) begin
			ray_mem[ray_waddr] <= ray_wdata;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			out_valid <= 1'b0;
		end else if (!in_stall) begin
			out_valid <= in_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			ray_q      <= ray_mem[in_ray_id];
			out_node   <= in_node;
			out_ray_id <= in_ray_id;
		end
	end

	// unpack origin, signs are the low three bits
	assign org_x = ray_q[RAY_W-1 -: COORD_W];
	assign org_y = ray_q[RAY_W-1-COORD_W -: COORD_W];
	assign org_z = ray_q[RAY_W-1-2*COORD_W -: COORD_W];

	// pick the split axis; leaves fall through to z
	always_comb begin
		case (out_node.inner.kind)
			NODE_SPLIT_X: begin
				out_origin  = org_x;
				out_dir_neg = ray_q[2];
			end
			NODE_SPLIT_Y: begin
				out_origin  = org_y;
				out_dir_neg = ray_q[1];
			end
			default: begin
				out_origin  = org_z;
				out_dir_neg = ray_q[0];
			end
		endcase
	end

endmodule

`default_nettype wire

// ==== verilog/node_fetch.sv ====
`default_nettype none

module node_fetch
	import rt_config_pkg::*;
	import rt_types_pkg::*;
(
	input  logic                 clk,
	input  logic                 rst,

	// store load port
	input  logic                 node_we,
	input  logic [NODE_ID_W-1:0] node_waddr,
	input  logic [NODE_W-1:0]    node_wdata,

	input  logic                 in_valid,
	input  logic [RAY_ID_W-1:0]  in_ray_id,
	input  logic [NODE_ID_W-1:0] in_node_id,
	output logic                 in_stall,

	output logic                 out_valid,
	output logic [RAY_ID_W-1:0]  out_ray_id,
	output tree_node_u           out_node,
	input  logic                 out_stall
);

	logic [NODE_W-1:0] node_mem [NUM_NODES];
	logic              accept;

	assign in_stall = out_valid && out_stall;
	assign accept   = in_valid && !in_stall;

	always_ff @(posedge clk) begin
		if (node_we) begin
			node_mem[node_waddr] <= node_wdata;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			out_valid <= 1'b0;
		end else if (!in_stall) begin
			out_valid <= in_valid;
		end
	end

	// synchronous read, data register holds while stalled
	always_ff @(posedge clk) begin
		if (accept) begin
			out_node   <= node_mem[in_node_id];
			out_ray_id <= in_ray_id;
		end
	end

endmodule

`default_nettype wire

// ==== verilog/job_arbiter.sv ====
`default_nettype none

module job_arbiter
	import rt_config_pkg::*;
(
	input  logic                 clk,
	input  logic                 rst,

	input  logic                 new_valid,
	input  logic [RAY_ID_W-1:0]  new_ray_id,
	input  logic [NODE_ID_W-1:0] new_node_id,
	output logic                 new_stall,

	input  logic                 rst_valid,
	input  logic [RAY_ID_W-1:0]  rst_ray_id,
	input  logic [NODE_ID_W-1:0] rst_node_id,
	output logic                 rst_stall,

	output logic                 out_valid,
	output logic [RAY_ID_W-1:0]  out_ray_id,
	output logic [NODE_ID_W-1:0] out_node_id,
	input  logic                 out_stall
);

	logic last_new;
	logic grant_new;
	logic grant_rst;
	logic hold;

	// output register full and not drained
	assign hold = out_valid && out_stall;

	// new rays win unless a restart waits and new won last time
	assign grant_new = new_valid && (!rst_valid || !last_new);
	assign grant_rst = rst_valid && !grant_new;

	assign new_stall = hold || (new_valid && !grant_new);
	assign rst_stall = hold || (rst_valid && !grant_rst);

	always_ff @(posedge clk) begin
		if (rst) begin
			last_new  <= 1'b0;
			out_valid <= 1'b0;
		end else if (!hold) begin
			out_valid <= grant_new || grant_rst;
			// flag only moves on an actual grant
			if (grant_new || grant_rst) begin
				last_new <= grant_new;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!hold) begin
			if (grant_new) begin
				out_ray_id  <= new_ray_id;
				out_node_id <= new_node_id;
			end else begin
				out_ray_id  <= rst_ray_id;
				out_node_id <= rst_node_id;
			end
		end
	end

endmodule

`default_nettype wire

// ==== verilog/rt_types_pkg.sv ====
`default_nettype none

package rt_types_pkg;
	import rt_config_pkg::*;

	localparam int KIND_W = 2;

	// node kind codes, split axis for inner nodes
	localparam logic [KIND_W-1:0] NODE_SPLIT_X = 2'd0;
	localparam logic [KIND_W-1:0] NODE_SPLIT_Y = 2'd1;
	localparam logic [KIND_W-1:0] NODE_SPLIT_Z = 2'd2;
	localparam logic [KIND_W-1:0] NODE_LEAF    = 2'd3;

	localparam int INNER_PAD_W = NODE_W - KIND_W - COORD_W - NODE_ID_W;
	localparam int LEAF_PAD_W  = NODE_W - KIND_W - LIST_W - COUNT_W;

	// inner node, children sit at left and left + 1
	typedef struct packed {
		logic [KIND_W-1:0]      kind;
		logic [COORD_W-1:0]     split;
		logic [NODE_ID_W-1:0]   left;
		logic [INNER_PAD_W-1:0] pad;
	} inner_node_t;

	typedef struct packed {
		logic [KIND_W-1:0]     kind;
		logic [LIST_W-1:0]     list;
		logic [COUNT_W-1:0]    count;
		logic [LEAF_PAD_W-1:0] pad;
	} leaf_node_t;

	// one node word, kind field is common to both views
	typedef union packed {
		inner_node_t inner;
		leaf_node_t  leaf;
	} tree_node_u;

endpackage

`default_nettype wire

// ==== verilog/rt_config_pkg.sv ====
`default_nettype none

package rt_config_pkg;

	// node store
	localparam int NODE_ID_W = 8;
	localparam int NUM_NODES = 256;
	localparam int NODE_W    = 32;

	// ray store
	localparam int RAY_ID_W  = 4;
	localparam int NUM_RAYS  = 16;

	// fixed-point coordinate, signed
	localparam int COORD_W   = 16;

	// ray word is {x, y, z, neg_x, neg_y, neg_z}, origin first
	localparam int RAY_W     = 3 * COORD_W + 3;

	// leaf payload
	localparam int LIST_W    = 16;
	localparam int COUNT_W   = 6;

endpackage

`default_nettype wire
